// ==== include/line_cache_defs.svh ====
`ifndef LINE_CACHE_DEFS_SVH
`define LINE_CACHE_DEFS_SVH

// byte address seen by the cpu
`define ADDR_W 32

// one cpu word
`define WORD_W 32

// one cache line, moved as a whole on the memory side
`define LINE_W 128
`define WORDS_PER_LINE 4

`endif

// ==== hdl/line_cache_pkg.sv ====
`default_nettype none

package line_cache_pkg;

    `include "line_cache_defs.svh"

    // address split derived from the shared widths
    localparam int unsigned WORD_SEL_W = $clog2(`WORDS_PER_LINE);
    localparam int unsigned BYTE_SEL_W = $clog2(`WORD_W / 8);
    localparam int unsigned LINE_ADDR_W = `ADDR_W - WORD_SEL_W - BYTE_SEL_W;

    typedef logic [`WORD_W-1:0] word_t;
    // line as an array of words, word 0 in the low bits
    typedef logic [`WORDS_PER_LINE-1:0][`WORD_W-1:0] line_t;
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;

    typedef struct packed {
        line_addr_t            line_addr;
        logic [WORD_SEL_W-1:0] word_sel;
        logic [BYTE_SEL_W-1:0] byte_sel;
    } addr_fields_t;

    // same 32 bits, raw word or line address plus offsets
    typedef union packed {
        logic [`ADDR_W-1:0] raw;
        addr_fields_t       fields;
    } cache_addr_t;

    // full line address kept as tag, index bits included
    typedef struct packed {
        logic       valid;
        logic       dirty;
        line_addr_t line_addr;
    } tag_entry_t;

    typedef struct packed {
        logic        valid;
        logic        we;
        cache_addr_t addr;
        word_t       wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  valid;
        word_t rdata;
    } cpu_resp_t;

    typedef struct packed {
        logic       valid;
        logic       we;
        line_addr_t line_addr;
        line_t      wline;
    } mem_req_t;

    typedef struct packed {
        logic  ack;
        line_t rline;
    } mem_resp_t;

endpackage

`default_nettype wire

// ==== hdl/tag_store.sv ====
`default_nettype none

module tag_store #(
    parameter int unsigned INDEX_W = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic [INDEX_W-1:0]         rd_index_i,
    input  logic [INDEX_W-1:0]         wr_index_i,
    input  logic                       wr_en_i,
    input  line_cache_pkg::tag_entry_t wr_entry_i,
    output line_cache_pkg::tag_entry_t rd_entry_o
);
    import line_cache_pkg::*;

    localparam int unsigned DEPTH = 2 ** INDEX_W;

    // one valid bit per index
    logic [DEPTH-1:0] valid_q;
    // dirty flag and tag per index
    tag_entry_t       entry_q [DEPTH];
    tag_entry_t       rd_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_index_i] <= wr_entry_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            entry_q[wr_index_i] <= wr_entry_i;
        end
    end

    // registered read returns the old entry on a same index write
    // valid field taken from valid_q
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_q <= '0;
        end else begin
            rd_q       <= entry_q[rd_index_i];
            rd_q.valid <= valid_q[rd_index_i];
        end
    end

    assign rd_entry_o = rd_q;

endmodule

`default_nettype wire

// ==== hdl/line_store.sv ====
`default_nettype none

module line_store #(
    parameter int unsigned INDEX_W = 4
) (
    input  logic                  clk_i,
    input  logic [INDEX_W-1:0]    rd_index_i,
    input  logic [INDEX_W-1:0]    wr_index_i,
    input  logic                  wr_en_i,
    input  line_cache_pkg::line_t wr_line_i,
    output line_cache_pkg::line_t rd_line_o
);
    import line_cache_pkg::*;

    localparam int unsigned DEPTH = 2 ** INDEX_W;

    // one full line per index
    line_t line_q [DEPTH];
    line_t rd_q;

    // whole line written at once, from a merge or a fetch
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            line_q[wr_index_i] <= wr_line_i;
        end
    end

    // read one cycle after the index, in step with tag_store
    always_ff @(posedge clk_i) begin
        rd_q <= line_q[rd_index_i];
    end

    assign rd_line_o = rd_q;

endmodule

`default_nettype wire

// ==== hdl/cache_ctrl.sv ====
`default_nettype none

module cache_ctrl #(
    parameter int unsigned INDEX_W = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // cpu side
    input  line_cache_pkg::cpu_req_t   cpu_req_i,
    output logic                       cpu_ready_o,
    output line_cache_pkg::cpu_resp_t  cpu_resp_o,
    // memory side
    output line_cache_pkg::mem_req_t   mem_req_o,
    input  line_cache_pkg::mem_resp_t  mem_resp_i,
    // tag store
    output logic [INDEX_W-1:0]         tag_rd_index_o,
    output logic [INDEX_W-1:0]         tag_wr_index_o,
    output logic                       tag_wr_en_o,
    output line_cache_pkg::tag_entry_t tag_wr_entry_o,
    input  line_cache_pkg::tag_entry_t tag_rd_i,
    // line store
    output logic [INDEX_W-1:0]         line_rd_index_o,
    output logic [INDEX_W-1:0]         line_wr_index_o,
    output logic                       line_wr_en_o,
    output line_cache_pkg::line_t      line_wr_o,
    input  line_cache_pkg::line_t      line_rd_i
);
    import line_cache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        COMPARE,
        WRITE_BACK,
        ALLOCATE
    } state_e;

    state_e state_q, state_d;

    // accepted request, held until the response
    logic        req_we_q;
    cache_addr_t req_addr_q;
    word_t       req_wdata_q;

    // memory request, registered so it stays stable until ack
    logic        mem_valid_q, mem_valid_d;
    logic        mem_we_q, mem_we_d;
    line_addr_t  mem_addr_q, mem_addr_d;
    line_t       mem_wline_q, mem_wline_d;

    logic               accept;
    logic               hit;
    logic [INDEX_W-1:0] index;
    line_t              merged_line;

    // only idle takes a new request
    assign cpu_ready_o = (state_q == IDLE);
    assign accept      = cpu_req_i.valid && cpu_ready_o;

    // index is the low line address bits
    assign index = req_addr_q.fields.line_addr[INDEX_W-1:0];

    // both stores read and write at the request index
    assign tag_rd_index_o  = index;
    assign tag_wr_index_o  = index;
    assign line_rd_index_o = index;
    assign line_wr_index_o = index;

    // full line address compare, tag entry holds it all
    assign hit = tag_rd_i.valid && (tag_rd_i.line_addr == req_addr_q.fields.line_addr);

    // store line with the write word dropped in
    always_comb begin
        merged_line = line_rd_i;
        if (req_we_q) begin
            merged_line[req_addr_q.fields.word_sel] = req_wdata_q;
        end
    end

    always_comb begin
        mem_req_o.valid     = mem_valid_q;
        mem_req_o.we        = mem_we_q;
        mem_req_o.line_addr = mem_addr_q;
        mem_req_o.wline     = mem_wline_q;
    end

    always_comb begin
        state_d     = state_q;
        mem_valid_d = mem_valid_q;
        mem_we_d    = mem_we_q;
        mem_addr_d  = mem_addr_q;
        mem_wline_d = mem_wline_q;

        // rdata is the merged word for a write, the stored word for a read
        cpu_resp_o.valid = 1'b0;
        cpu_resp_o.rdata = merged_line[req_addr_q.fields.word_sel];

        tag_wr_en_o    = 1'b0;
        tag_wr_entry_o = '0;
        line_wr_en_o   = 1'b0;
        line_wr_o      = merged_line;

        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = LOOKUP;
                end
            end
            // stores see the index this cycle
            LOOKUP: begin
                state_d = COMPARE;
            end
            COMPARE: begin
                if (hit) begin
                    cpu_resp_o.valid = 1'b1;
                    // write hit, merged line back and mark dirty
                    if (req_we_q) begin
                        tag_wr_en_o    = 1'b1;
                        tag_wr_entry_o = '{
                            valid:     1'b1,
                            dirty:     1'b1,
                            line_addr: req_addr_q.fields.line_addr
                        };
                        line_wr_en_o   = 1'b1;
                    end
                    state_d = IDLE;
                end else begin
                    mem_valid_d = 1'b1;
                    mem_wline_d = line_rd_i;
                    if (tag_rd_i.valid && tag_rd_i.dirty) begin
                        // dirty victim goes out at its own line address
                        mem_we_d   = 1'b1;
                        mem_addr_d = tag_rd_i.line_addr;
                        state_d    = WRITE_BACK;
                    end else begin
                        // clean or empty, straight to the fetch
                        mem_we_d   = 1'b0;
                        mem_addr_d = req_addr_q.fields.line_addr;
                        state_d    = ALLOCATE;
                    end
                end
            end
            WRITE_BACK: begin
                // victim taken, turn the request into the fetch
                if (mem_resp_i.ack) begin
                    mem_we_d   = 1'b0;
                    mem_addr_d = req_addr_q.fields.line_addr;
                    state_d    = ALLOCATE;
                end
            end
            ALLOCATE: begin
                if (mem_resp_i.ack) begin
                    mem_valid_d    = 1'b0;
                    // fill line, clean tag, then re-read as a hit
                    tag_wr_en_o    = 1'b1;
                    tag_wr_entry_o = '{
                        valid:     1'b1,
                        dirty:     1'b0,
                        line_addr: req_addr_q.fields.line_addr
                    };
                    line_wr_en_o   = 1'b1;
                    line_wr_o      = mem_resp_i.rline;
                    state_d        = LOOKUP;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= IDLE;
            mem_valid_q <= 1'b0;
            mem_we_q    <= 1'b0;
        end else begin
            state_q     <= state_d;
            mem_valid_q <= mem_valid_d;
            mem_we_q    <= mem_we_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_we_q    <= cpu_req_i.we;
            req_addr_q  <= cpu_req_i.addr;
            req_wdata_q <= cpu_req_i.wdata;
        end
        mem_addr_q  <= mem_addr_d;
        mem_wline_q <= mem_wline_d;
    end

endmodule

`default_nettype wire

// ==== hdl/line_cache.sv ====
`default_nettype none

module line_cache #(
    parameter int unsigned INDEX_W = 4
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  line_cache_pkg::cpu_req_t  cpu_req_i,
    output logic                      cpu_ready_o,
    output line_cache_pkg::cpu_resp_t cpu_resp_o,
    output line_cache_pkg::mem_req_t  mem_req_o,
    input  line_cache_pkg::mem_resp_t mem_resp_i
);
    import line_cache_pkg::*;

    // tag store wires
    logic [INDEX_W-1:0] tag_rd_index;
    logic [INDEX_W-1:0] tag_wr_index;
    logic               tag_wr_en;
    tag_entry_t         tag_wr_entry;
    tag_entry_t         tag_rd;

    // line store wires
    logic [INDEX_W-1:0] line_rd_index;
    logic [INDEX_W-1:0] line_wr_index;
    logic               line_wr_en;
    line_t              line_wr;
    line_t              line_rd;

    tag_store #(
        .INDEX_W(INDEX_W)
    ) tag_store_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .rd_index_i (tag_rd_index),
        .wr_index_i (tag_wr_index),
        .wr_en_i    (tag_wr_en),
        .wr_entry_i (tag_wr_entry),
        .rd_entry_o (tag_rd)
    );

    line_store #(
        .INDEX_W(INDEX_W)
    ) line_store_i (
        .clk_i      (clk_i),
        .rd_index_i (line_rd_index),
        .wr_index_i (line_wr_index),
        .wr_en_i    (line_wr_en),
        .wr_line_i  (line_wr),
        .rd_line_o  (line_rd)
    );

    cache_ctrl #(
        .INDEX_W(INDEX_W)
    ) cache_ctrl_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .cpu_req_i       (cpu_req_i),
        .cpu_ready_o     (cpu_ready_o),
        .cpu_resp_o      (cpu_resp_o),
        .mem_req_o       (mem_req_o),
        .mem_resp_i      (mem_resp_i),
        .tag_rd_index_o  (tag_rd_index),
        .tag_wr_index_o  (tag_wr_index),
        .tag_wr_en_o     (tag_wr_en),
        .tag_wr_entry_o  (tag_wr_entry),
        .tag_rd_i        (tag_rd),
        .line_rd_index_o (line_rd_index),
        .line_wr_index_o (line_wr_index),
        .line_wr_en_o    (line_wr_en),
        .line_wr_o       (line_wr),
        .line_rd_i       (line_rd)
    );

endmodule

`default_nettype wire

// ==== verification/line_cache_properties.sv ====
`default_nettype none

module line_cache_properties (
    input logic                      clk_i,
    input logic                      rst_ni,
    input line_cache_pkg::cpu_req_t  cpu_req_i,
    input logic                      cpu_ready_o,
    input line_cache_pkg::cpu_resp_t cpu_resp_o,
    input line_cache_pkg::mem_req_t  mem_req_o,
    input line_cache_pkg::mem_resp_t mem_resp_i
);

    // high from acceptance to the response edge
    logic pending_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (cpu_req_i.valid && cpu_ready_o) begin
            pending_q <= 1'b1;
        end else if (cpu_resp_o.valid) begin
            pending_q <= 1'b0;
        end
    end

    // memory request frozen until its ack
    mem_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o.valid && !mem_resp_i.ack |=> mem_req_o.valid && $stable(mem_req_o))
        else $error("memory request changed before ack");

    resp_has_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cpu_resp_o.valid |-> pending_q)
        else $error("response without an accepted request");

    // single outstanding request
    ready_low_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pending_q |-> !cpu_ready_o)
        else $error("cpu ready high with a request outstanding");

endmodule

bind cache_ctrl line_cache_properties props_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cpu_req_i   (cpu_req_i),
    .cpu_ready_o (cpu_ready_o),
    .cpu_resp_o  (cpu_resp_o),
    .mem_req_o   (mem_req_o),
    .mem_resp_i  (mem_resp_i)
);

`default_nettype wire

// ==== verification/line_cache_tb.sv ====
`default_nettype none

`include "line_cache_defs.svh"

module line_cache_tb;
    import line_cache_pkg::*;

    localparam int unsigned INDEX_W = 4;
    localparam int unsigned WPL = `WORDS_PER_LINE;
    localparam int TIMEOUT = 200;
    localparam int N_OPS = 3000;
    // test lines sit above zero so tags carry high bits
    localparam logic [31:0] BASE = 32'h0040_0000;

    logic      clk_i = 1'b0;
    logic      rst_ni;
    cpu_req_t  cpu_req;
    logic      cpu_ready;
    cpu_resp_t cpu_resp;
    mem_req_t  mem_req;
    mem_resp_t mem_resp;

    int errors;
    int checks;
    int mem_writes;
    bit stalled;
    // memory model handshake state
    bit          mem_busy;
    int unsigned mem_wait;

    // flat reference words, memory model lines, lines written since fetch
    word_t ref_mem [bit [29:0]];
    line_t mem_lines [bit [27:0]];
    bit    dirty_exp [bit [27:0]];

    line_cache #(
        .INDEX_W(INDEX_W)
    ) line_cache_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cpu_req_i   (cpu_req),
        .cpu_ready_o (cpu_ready),
        .cpu_resp_o  (cpu_resp),
        .mem_req_o   (mem_req),
        .mem_resp_i  (mem_resp)
    );

    always #10 clk_i = ~clk_i;

    // untouched memory, pattern over the whole word address
    function automatic word_t init_word(input bit [29:0] wa);
        return {wa, 2'b00} ^ 32'h9e37_79b9;
    endfunction

    function automatic word_t ref_word(input bit [29:0] wa);
        if (ref_mem.exists(wa)) begin
            return ref_mem[wa];
        end
        return init_word(wa);
    endfunction

    function automatic line_t mem_line(input bit [27:0] la);
        line_t l;
        if (mem_lines.exists(la)) begin
            return mem_lines[la];
        end
        for (int w = 0; w < WPL; w++) begin
            l[2'(w)] = init_word({la, 2'(w)});
        end
        return l;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    // one falling edge of the memory model, ack after 1 to 5 cycles
    task automatic serve_memory();
        bit [27:0] la;
        if (mem_resp.ack) begin
            mem_resp.ack = 1'b0;
        end else if (mem_req.valid) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = $urandom % 5;
            end
            if (mem_wait != 0) begin
                mem_wait--;
            end else begin
                mem_busy = 1'b0;
                la = mem_req.line_addr;
                if (mem_req.we) begin
                    mem_writes++;
                    // clean lines never come back
                    check_value("write-back of a dirty line", 32'd1,
                                32'(dirty_exp.exists(la) && dirty_exp[la]));
                    for (int w = 0; w < WPL; w++) begin
                        check_value("write-back data", ref_word({la, 2'(w)}),
                                    mem_req.wline[2'(w)]);
                    end
                    mem_lines[la] = mem_req.wline;
                    dirty_exp[la] = 1'b0;
                end else begin
                    // a dirty line at the same index must have left first
                    foreach (dirty_exp[d]) begin
                        if (dirty_exp[d] && d != la && d[INDEX_W-1:0] == la[INDEX_W-1:0]) begin
                            errors++;
                            $display("ERROR: fetch of line %h before write-back of line %h",
                                     la, d);
                        end
                    end
                    mem_resp.rline = mem_line(la);
                end
                mem_resp.ack = 1'b1;
            end
        end
    endtask

    // one cpu request, lat counts edges from acceptance to the response
    task automatic cpu_access(input bit we, input word_t addr, input word_t wdata,
                              output word_t rdata, output int lat);
        int n;
        bit got;
        rdata = '0;
        lat = 0;
        n = 0;
        got = 1'b0;
        if (stalled) begin
            return;
        end
        @(negedge clk_i);
        while (!cpu_ready && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!cpu_ready) begin
            errors++;
            stalled = 1'b1;
            $display("ERROR: cpu_ready_o stayed low for %0d cycles", TIMEOUT);
            return;
        end
        cpu_req.valid = 1'b1;
        cpu_req.we = we;
        cpu_req.addr.raw = addr;
        cpu_req.wdata = wdata;
        @(posedge clk_i);
        while (!got && lat < TIMEOUT) begin
            @(negedge clk_i);
            lat++;
            cpu_req = '0;
            serve_memory();
            if (cpu_resp.valid) begin
                got = 1'b1;
                rdata = cpu_resp.rdata;
            end
        end
        if (!got) begin
            errors++;
            stalled = 1'b1;
            $display("ERROR: no response within %0d cycles of address %h", TIMEOUT, addr);
            return;
        end
        if (we) begin
            ref_mem[addr[31:2]] = wdata;
            dirty_exp[addr[31:4]] = 1'b1;
        end
    endtask

    initial begin
        word_t     a;
        word_t     b;
        word_t     rd;
        word_t     wd;
        bit        we;
        int        lat;
        int        w0;
        line_t     l;
        bit [27:0] la;
        void'($urandom(10));
        rst_ni = 1'b0;
        cpu_req = '0;
        mem_resp = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        check_value("ready after reset", 32'd1, 32'(cpu_ready));
        check_value("resp valid after reset", 32'd0, 32'(cpu_resp.valid));
        check_value("mem valid after reset", 32'd0, 32'(mem_req.valid));

        // cold read, then resident read and write hit
        a = BASE + 32'h0000_0124;
        cpu_access(1'b0, a, '0, rd, lat);
        check_value("first read", ref_word(a[31:2]), rd);
        cpu_access(1'b0, a, '0, rd, lat);
        check_value("resident read", ref_word(a[31:2]), rd);
        check_value("resident read latency", 32'd2, 32'(lat));
        cpu_access(1'b1, a, 32'h1234_5678, rd, lat);
        check_value("write hit word", 32'h1234_5678, rd);
        check_value("write hit latency", 32'd2, 32'(lat));

        // same index, dirty line a must go out
        b = a + (32'd1 << (INDEX_W + 4));
        w0 = mem_writes;
        cpu_access(1'b0, b, '0, rd, lat);
        check_value("conflict read", ref_word(b[31:2]), rd);
        check_value("dirty victim writes", 32'(w0 + 1), 32'(mem_writes));
        l = mem_line(a[31:4]);
        check_value("evicted word in memory", 32'h1234_5678, l[a[3:2]]);
        // b is clean now, no second write
        cpu_access(1'b0, b + (32'd1 << (INDEX_W + 4)), '0, rd, lat);
        check_value("clean victim writes", 32'(w0 + 1), 32'(mem_writes));

        // mixed traffic over 64 lines
        for (int i = 0; i < N_OPS; i++) begin
            a = BASE + (($urandom % 64) << 4) + (($urandom % 4) << 2);
            we = ($urandom % 2) == 1;
            wd = $urandom;
            cpu_access(we, a, wd, rd, lat);
            if (we) begin
                check_value("random write", wd, rd);
            end else begin
                check_value("random read", ref_word(a[31:2]), rd);
            end
        end

        // read everything back, then compare memory for clean lines
        for (int ln = 0; ln < 64; ln++) begin
            for (int w = 0; w < WPL; w++) begin
                a = BASE + 32'(ln << 4) + 32'(w << 2);
                cpu_access(1'b0, a, '0, rd, lat);
                check_value("final read", ref_word(a[31:2]), rd);
            end
        end
        for (int ln = 0; ln < 64; ln++) begin
            la = 28'(BASE >> 4) + 28'(ln);
            if (!(dirty_exp.exists(la) && dirty_exp[la])) begin
                l = mem_line(la);
                for (int w = 0; w < WPL; w++) begin
                    check_value("memory at end", ref_word({la, 2'(w)}), l[2'(w)]);
                end
            end
        end

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== line_cache.f ====
+incdir+include
hdl/line_cache_pkg.sv
hdl/tag_store.sv
hdl/line_store.sv
hdl/cache_ctrl.sv
hdl/line_cache.sv
verification/line_cache_properties.sv
verification/line_cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module line_cache_tb \
    -f line_cache.f -o line_cache_sim \
    && ./obj_dir/line_cache_sim | tee sim.log \
    || echo "build or simulation error"
grep -q "Test completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
